/* hw/cadr_alu_pkg.sv */
// ------------------------------
// widths are fixed by the slices
// ------------------------------
package cadr_alu_pkg;

   // data path width
   localparam int WORD_W = 32;

   // one extra slice bit holds the sign of bit 31
   localparam int ALU_W = WORD_W + 1;

   // operation select on i_op
   localparam logic OP_ALU = 1'b0;
   localparam logic OP_MUL = 1'b1;

   // 181 function codes, active-high data
   // arithmetic mode, F = A plus B plus carry
   localparam logic [3:0] ALUF_ADD = 4'b1001;

   // logic mode, F = B
   localparam logic [3:0] ALUF_PASS_B = 4'b1010;

   // arithmetic mode, F = A minus B minus 1 plus carry
   localparam logic [3:0] ALUF_SUB = 4'b0110;

   // one step per multiplier bit
   localparam int MUL_STEPS = 32;

endpackage

/* hw/alu_slice_181.sv */
`timescale 1ns/1ns
// ------------------------------
// active-high data, carries active low
// o_x, o_y are low-true P and G
// ------------------------------
module alu_slice_181 (
   input  logic [3:0] i_a,
   input  logic [3:0] i_b,
   input  logic [3:0] i_s,
   input  logic       i_m,
   input  logic       i_cin_n,
   output logic [3:0] o_f,
   output logic       o_x,
   output logic       o_y,
   output logic       o_cout_n,
   output logic       o_aeb
);

   logic [3:0] p;
   logic [3:0] g;
   logic [3:0] h;
   logic [4:0] c;

   // the part adds two selected terms of A and B
   // first term, also the bit propagate
   assign p = i_a | (i_b & {4{i_s[0]}}) | (~i_b & {4{i_s[1]}});

   // second term, also the bit generate
   assign g = (i_a & ~i_b & {4{i_s[2]}}) | (i_a & i_b & {4{i_s[3]}});

   // g never set without p, so p ^ g is the half sum
   assign h = p ^ g;

   // internal ripple, held active high
   always_comb begin
      c[0] = ~i_cin_n;
      for (int i = 0; i < 4; i++) begin
         c[i+1] = g[i] | (p[i] & c[i]);
      end
   end

   // logic mode ignores the carries
   assign o_f = i_m ? ~h : (h ^ c[3:0]);

   assign o_cout_n = ~c[4];

   // lookahead terms for the 182
   assign o_x = ~(&p);
   assign o_y = ~(g[3] |
                  (p[3] & g[2]) |
                  (p[3] & p[2] & g[1]) |
                  (p[3] & p[2] & p[1] & g[0]));

   // open-collector A=B on the part
   assign o_aeb = &o_f;

endmodule

/* hw/alu_carry_182.sv */
`timescale 1ns/1ns
// ------------------------------
// all inputs and outputs low-true
// ------------------------------
module alu_carry_182 (
   input  logic [3:0] i_x,
   input  logic [3:0] i_y,
   input  logic       i_cin_n,
   output logic       o_c1_n,
   output logic       o_c2_n,
   output logic       o_c3_n,
   output logic       o_x,
   output logic       o_y
);

   logic [3:0] p;
   logic [3:0] g;
   logic       c0;

   // back to active high for the equations
   assign p  = ~i_x;
   assign g  = ~i_y;
   assign c0 = ~i_cin_n;

   assign o_c1_n = ~(g[0] | (p[0] & c0));

   assign o_c2_n = ~(g[1] |
                     (p[1] & g[0]) |
                     (p[1] & p[0] & c0));

   assign o_c3_n = ~(g[2] |
                     (p[2] & g[1]) |
                     (p[2] & p[1] & g[0]) |
                     (p[2] & p[1] & p[0] & c0));

   // group terms for the next lookahead level
   assign o_x = ~(&p);
   assign o_y = ~(g[3] |
                  (p[3] & g[2]) |
                  (p[3] & p[2] & g[1]) |
                  (p[3] & p[2] & p[1] & g[0]));

endmodule

/* hw/alu_word.sv */
`timescale 1ns/1ns
// ------------------------------
// A input is i_m, B input is i_a
// carries come back from the 182s
// ------------------------------
module alu_word (
   input  logic [cadr_alu_pkg::WORD_W-1:0] i_a,
   input  logic [cadr_alu_pkg::WORD_W-1:0] i_m,
   input  logic [3:0]                      i_aluf,
   input  logic                            i_alumode,
   input  logic                            i_cin0,
   input  logic                            i_cin4_n,
   input  logic                            i_cin8_n,
   input  logic                            i_cin12_n,
   input  logic                            i_cin16_n,
   input  logic                            i_cin20_n,
   input  logic                            i_cin24_n,
   input  logic                            i_cin28_n,
   input  logic                            i_cin32_n,
   output logic [cadr_alu_pkg::ALU_W-1:0]  o_alu,
   output logic                            o_aeqm,
   output logic [7:0]                      o_x,
   output logic [7:0]                      o_y
);

   import cadr_alu_pkg::*;

   localparam int NSLICE = WORD_W / 4;

   logic [NSLICE-1:0] cin_n;
   logic [NSLICE-1:0] aeb;
   logic [3:0]        sign_f;

   // slice carry-ins, cin0 is the only active-high one
   assign cin_n = {i_cin28_n, i_cin24_n, i_cin20_n, i_cin16_n,
                   i_cin12_n, i_cin8_n, i_cin4_n, ~i_cin0};

   genvar gi;
   generate
      for (gi = 0; gi < NSLICE; gi++) begin : g_slice
         alu_slice_181 u_slice (
            .i_a      (i_m[4*gi +: 4]),
            .i_b      (i_a[4*gi +: 4]),
            .i_s      (i_aluf),
            .i_m      (i_alumode),
            .i_cin_n  (cin_n[gi]),
            .o_f      (o_alu[4*gi +: 4]),
            .o_x      (o_x[gi]),
            .o_y      (o_y[gi]),
            .o_cout_n (),
            .o_aeb    (aeb[gi])
         );
      end
   endgenerate

   // ninth slice works bit 31 again to give bit 32
   alu_slice_181 u_sign_slice (
      .i_a      ({3'b000, i_m[WORD_W-1]}),
      .i_b      ({3'b000, i_a[WORD_W-1]}),
      .i_s      (i_aluf),
      .i_m      (i_alumode),
      .i_cin_n  (i_cin32_n),
      .o_f      (sign_f),
      .o_x      (),
      .o_y      (),
      .o_cout_n (),
      .o_aeb    ()
   );

   assign o_alu[ALU_W-1] = sign_f[0];

   // wired-AND of the eight A=B outputs
   assign o_aeqm = &aeb;

endmodule

/* hw/alu_shift_regs.sv */
`timescale 1ns/1ns
// ------------------------------
// load, capture and shift are one-hot
// ------------------------------
module alu_shift_regs (
   input  logic                            i_clk,
   input  logic                            i_rst_n,
   input  logic                            i_load_alu,
   input  logic                            i_load_mul,
   input  logic                            i_capture,
   input  logic                            i_shift,
   input  logic [cadr_alu_pkg::WORD_W-1:0] i_a,
   input  logic [cadr_alu_pkg::WORD_W-1:0] i_m,
   input  logic [cadr_alu_pkg::ALU_W-1:0]  i_alu,
   input  logic                            i_aeqm,
   output logic [cadr_alu_pkg::ALU_W-1:0]  o_acc,
   output logic [cadr_alu_pkg::WORD_W-1:0] o_q,
   output logic [cadr_alu_pkg::WORD_W-1:0] o_mreg,
   output logic                            o_aeqm
);

   import cadr_alu_pkg::*;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_acc  <= '0;
         o_q    <= '0;
         o_mreg <= '0;
         o_aeqm <= 1'b0;
      end else if (i_load_alu) begin
         // operand A sits in the accumulator as the B input
         o_acc  <= {i_a[WORD_W-1], i_a};
         o_q    <= '0;
         o_mreg <= i_m;
         o_aeqm <= 1'b0;
      end else if (i_load_mul) begin
         // multiplier goes to Q, partial product starts at zero
         o_acc  <= '0;
         o_q    <= i_a;
         o_mreg <= i_m;
         o_aeqm <= 1'b0;
      end else if (i_capture) begin
         o_acc  <= i_alu;
         o_aeqm <= i_aeqm;
      end else if (i_shift) begin
         // acc and Q shift right as one 65-bit word
         o_acc <= {i_alu[ALU_W-1], i_alu[ALU_W-1:1]};
         o_q   <= {i_alu[0], o_q[WORD_W-1:1]};
      end
   end

endmodule

/* hw/alu_step_counter.sv */
`timescale 1ns/1ns
// ------------------------------
// o_last high on the final step
// ------------------------------
module alu_step_counter (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_load,
   input  logic i_step,
   output logic o_last
);

   import cadr_alu_pkg::*;

   localparam int CNT_W = $clog2(MUL_STEPS);

   logic [CNT_W-1:0] count;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         count <= '0;
      end else if (i_load) begin
         count <= CNT_W'(MUL_STEPS - 1);
      end else if (i_step) begin
         // wraps after the last step, reloaded on next start
         count <= count - 1'b1;
      end
   end

   assign o_last = (count == '0);

endmodule

/* hw/alu_sequencer.sv */
`timescale 1ns/1ns
// ------------------------------
// i_start is ignored unless idle
// ------------------------------
module alu_sequencer (
   input  logic       i_clk,
   input  logic       i_rst_n,
   input  logic       i_start,
   input  logic       i_op,
   input  logic [3:0] i_aluf,
   input  logic       i_alumode,
   input  logic       i_cin0,
   input  logic       i_q0,
   input  logic       i_last,
   output logic [3:0] o_aluf,
   output logic       o_alumode,
   output logic       o_cin0,
   output logic       o_load_alu,
   output logic       o_load_mul,
   output logic       o_capture,
   output logic       o_shift,
   output logic       o_cnt_load,
   output logic       o_step,
   output logic       o_busy,
   output logic       o_done
);

   import cadr_alu_pkg::*;

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ALU  = 2'd1;
   localparam logic [1:0] ST_MUL  = 2'd2;
   localparam logic [1:0] ST_DONE = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic [3:0] aluf_q;
   logic       alumode_q;
   logic       cin0_q;
   logic       accept;

   assign accept = (state == ST_IDLE) && i_start;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= ST_IDLE;
         aluf_q    <= '0;
         alumode_q <= 1'b0;
         cin0_q    <= 1'b0;
      end else begin
         state <= state_nxt;
         // function held for the single ALU cycle
         if (accept) begin
            aluf_q    <= i_aluf;
            alumode_q <= i_alumode;
            cin0_q    <= i_cin0;
         end
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (i_start) begin
               state_nxt = (i_op == OP_MUL) ? ST_MUL : ST_ALU;
            end
         end
         ST_ALU:  state_nxt = ST_DONE;
         ST_MUL: begin
            if (i_last) begin
               state_nxt = ST_DONE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   // multiply step: add multiplicand if Q bit 0 set, else pass acc
   always_comb begin
      if (state == ST_MUL) begin
         o_aluf    = i_q0 ? ALUF_ADD : ALUF_PASS_B;
         o_alumode = ~i_q0;
         o_cin0    = 1'b0;
      end else begin
         o_aluf    = aluf_q;
         o_alumode = alumode_q;
         o_cin0    = cin0_q;
      end
   end

   assign o_load_alu = accept && (i_op == OP_ALU);
   assign o_load_mul = accept && (i_op == OP_MUL);
   assign o_cnt_load = o_load_mul;
   assign o_capture  = (state == ST_ALU);
   assign o_shift    = (state == ST_MUL);
   assign o_step     = (state == ST_MUL);
   assign o_busy     = (state != ST_IDLE);
   assign o_done     = (state == ST_DONE);

endmodule

/* hw/cadr_alu_unit.sv */
`timescale 1ns/1ns
// ------------------------------
// ALU op takes 2 cycles, multiply 33
// ------------------------------
module cadr_alu_unit (
   input  logic                            i_clk,
   input  logic                            i_rst_n,
   input  logic                            i_start,
   input  logic                            i_op,
   input  logic [3:0]                      i_aluf,
   input  logic                            i_alumode,
   input  logic                            i_cin0,
   input  logic [cadr_alu_pkg::WORD_W-1:0] i_a,
   input  logic [cadr_alu_pkg::WORD_W-1:0] i_m,
   output logic                            o_busy,
   output logic                            o_done,
   output logic [cadr_alu_pkg::ALU_W-1:0]  o_acc,
   output logic [cadr_alu_pkg::WORD_W-1:0] o_q,
   output logic                            o_aeqm
);

   import cadr_alu_pkg::*;

   logic [3:0]        seq_aluf;
   logic              seq_alumode;
   logic              seq_cin0;
   logic              load_alu;
   logic              load_mul;
   logic              capture;
   logic              shift;
   logic              cnt_load;
   logic              step;
   logic              last;
   logic [WORD_W-1:0] mreg;
   logic [ALU_W-1:0]  alu;
   logic              alu_aeqm;
   logic [7:0]        alu_x;
   logic [7:0]        alu_y;
   logic              c4_n;
   logic              c8_n;
   logic              c12_n;
   logic              c16_n;
   logic              c20_n;
   logic              c24_n;
   logic              c28_n;
   logic              c32_n;
   logic              lo_x;
   logic              lo_y;
   logic              hi_x;
   logic              hi_y;

   alu_sequencer u_sequencer (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_start    (i_start),
      .i_op       (i_op),
      .i_aluf     (i_aluf),
      .i_alumode  (i_alumode),
      .i_cin0     (i_cin0),
      .i_q0       (o_q[0]),
      .i_last     (last),
      .o_aluf     (seq_aluf),
      .o_alumode  (seq_alumode),
      .o_cin0     (seq_cin0),
      .o_load_alu (load_alu),
      .o_load_mul (load_mul),
      .o_capture  (capture),
      .o_shift    (shift),
      .o_cnt_load (cnt_load),
      .o_step     (step),
      .o_busy     (o_busy),
      .o_done     (o_done)
   );

   alu_step_counter u_step_counter (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_load  (cnt_load),
      .i_step  (step),
      .o_last  (last)
   );

   alu_shift_regs u_shift_regs (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_load_alu (load_alu),
      .i_load_mul (load_mul),
      .i_capture  (capture),
      .i_shift    (shift),
      .i_a        (i_a),
      .i_m        (i_m),
      .i_alu      (alu),
      .i_aeqm     (alu_aeqm),
      .o_acc      (o_acc),
      .o_q        (o_q),
      .o_mreg     (mreg),
      .o_aeqm     (o_aeqm)
   );

   // B side is the accumulator, A side the multiplicand
   alu_word u_alu_word (
      .i_a       (o_acc[WORD_W-1:0]),
      .i_m       (mreg),
      .i_aluf    (seq_aluf),
      .i_alumode (seq_alumode),
      .i_cin0    (seq_cin0),
      .i_cin4_n  (c4_n),
      .i_cin8_n  (c8_n),
      .i_cin12_n (c12_n),
      .i_cin16_n (c16_n),
      .i_cin20_n (c20_n),
      .i_cin24_n (c24_n),
      .i_cin28_n (c28_n),
      .i_cin32_n (c32_n),
      .o_alu     (alu),
      .o_aeqm    (alu_aeqm),
      .o_x       (alu_x),
      .o_y       (alu_y)
   );

   // slices 0 to 3
   alu_carry_182 u_carry_lo (
      .i_x     (alu_x[3:0]),
      .i_y     (alu_y[3:0]),
      .i_cin_n (~seq_cin0),
      .o_c1_n  (c4_n),
      .o_c2_n  (c8_n),
      .o_c3_n  (c12_n),
      .o_x     (lo_x),
      .o_y     (lo_y)
   );

   // second level, unused inputs tied inactive high
   alu_carry_182 u_carry_mid (
      .i_x     ({2'b11, hi_x, lo_x}),
      .i_y     ({2'b11, hi_y, lo_y}),
      .i_cin_n (~seq_cin0),
      .o_c1_n  (c16_n),
      .o_c2_n  (c32_n),
      .o_c3_n  (),
      .o_x     (),
      .o_y     ()
   );

   // slices 4 to 7
   alu_carry_182 u_carry_hi (
      .i_x     (alu_x[7:4]),
      .i_y     (alu_y[7:4]),
      .i_cin_n (c16_n),
      .o_c1_n  (c20_n),
      .o_c2_n  (c24_n),
      .o_c3_n  (c28_n),
      .o_x     (hi_x),
      .o_y     (hi_y)
   );

endmodule

/* verif/cadr_alu_props.sv */
`timescale 1ns/1ns
// ------------------------------
// watches top-level ports only
// ------------------------------
module cadr_alu_props (
   input logic i_clk,
   input logic i_rst_n,
   input logic i_start,
   input logic i_op,
   input logic i_busy,
   input logic i_done
);

   import cadr_alu_pkg::*;

   localparam int MUL_LAT = MUL_STEPS + 1;

   logic accept_alu;
   logic accept_mul;

   // start only counts while idle
   assign accept_alu = i_start && !i_busy && (i_op == OP_ALU);
   assign accept_mul = i_start && !i_busy && (i_op == OP_MUL);

   done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_done |=> !i_done)
      else $error("o_done high for more than one cycle");

   alu_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      accept_alu |-> ##2 i_done)
      else $error("o_done missing 2 cycles after ALU start");

   mul_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      accept_mul |-> ##MUL_LAT i_done)
      else $error("o_done missing 33 cycles after multiply start");

   reset_idle: assert property (@(posedge i_clk)
      !i_rst_n |=> !i_busy)
      else $error("o_busy high after reset");

endmodule

bind cadr_alu_unit cadr_alu_props u_props (
   .i_clk   (i_clk),
   .i_rst_n (i_rst_n),
   .i_start (i_start),
   .i_op    (i_op),
   .i_busy  (o_busy),
   .i_done  (o_done)
);

/* verif/tb_cadr_alu_unit.sv */
`timescale 1ns/1ns
// ------------------------------
// expected values from the 181 function table
// inputs change on the falling edge only
// ------------------------------
module tb_cadr_alu_unit;

   import cadr_alu_pkg::*;

   localparam int ROWS       = 40;
   localparam int TIMEOUT    = 100;

   // start edge to done pulse, in clock cycles
   localparam int ALU_CYCLES = 2;
   localparam int MUL_CYCLES = MUL_STEPS + 1;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              start;
   logic              op;
   logic [3:0]        aluf;
   logic              alumode;
   logic              cin0;
   logic [WORD_W-1:0] a;
   logic [WORD_W-1:0] m;
   logic              busy;
   logic              done;
   logic [ALU_W-1:0]  acc;
   logic [WORD_W-1:0] q;
   logic              aeqm;

   // one row of stimulus and expected values per test
   string             row_name [ROWS];
   logic              row_op   [ROWS];
   logic [3:0]        row_aluf [ROWS];
   logic              row_mode [ROWS];
   logic              row_cin  [ROWS];
   logic [WORD_W-1:0] row_a    [ROWS];
   logic [WORD_W-1:0] row_m    [ROWS];
   logic [ALU_W-1:0]  row_acc  [ROWS];
   logic [WORD_W-1:0] row_q    [ROWS];
   logic              row_aeqm [ROWS];

   int   nrows;
   int   errors;
   int   tests_ok;
   int   tests_bad;
   logic test_bad;

   cadr_alu_unit u_cadr_alu_unit (
      .i_clk     (clk),
      .i_rst_n   (rst_n),
      .i_start   (start),
      .i_op      (op),
      .i_aluf    (aluf),
      .i_alumode (alumode),
      .i_cin0    (cin0),
      .i_a       (a),
      .i_m       (m),
      .o_busy    (busy),
      .o_done    (done),
      .o_acc     (acc),
      .o_q       (q),
      .o_aeqm    (aeqm)
   );

   always #50 clk = ~clk;

   // 181 table on sign-extended A (multiplicand) and B (accumulator)
   function automatic logic [ALU_W-1:0] alu_model(input logic [3:0] f, input logic mode,
                                                   input logic cin, input logic [31:0] av,
                                                   input logic [31:0] mv);
      logic [ALU_W-1:0] xb;
      logic [ALU_W-1:0] xa;
      logic [ALU_W-1:0] r;
      xb = {av[31], av};
      xa = {mv[31], mv};
      r  = '0;
      if (mode) begin
         case (f)
            4'b0000: r = ~xa;
            4'b0001: r = ~(xa | xb);
            4'b0010: r = ~xa & xb;
            4'b0011: r = '0;
            4'b0100: r = ~(xa & xb);
            4'b0101: r = ~xb;
            4'b0110: r = xa ^ xb;
            4'b0111: r = xa & ~xb;
            4'b1000: r = ~xa | xb;
            4'b1001: r = ~(xa ^ xb);
            4'b1010: r = xb;
            4'b1011: r = xa & xb;
            4'b1100: r = '1;
            4'b1101: r = xa | ~xb;
            4'b1110: r = xa | xb;
            default: r = xa;
         endcase
      end else if (f == ALUF_ADD) begin
         r = xa + xb + cin;
      end else if (f == ALUF_SUB) begin
         r = xa - xb - 33'd1 + cin;
      end
      return r;
   endfunction

   // signed multiplicand times unsigned multiplier
   function automatic logic [63:0] mul_model(input logic [31:0] av, input logic [31:0] mv);
      logic [63:0] sm;
      logic [63:0] ua;
      sm = {{32{mv[31]}}, mv};
      ua = {32'd0, av};
      return sm * ua;
   endfunction

   task automatic add_row(input string name, input logic o, input logic [3:0] f,
                          input logic mode, input logic cin, input logic [31:0] av,
                          input logic [31:0] mv);
      logic [63:0]      p;
      logic [ALU_W-1:0] r;
      row_name[nrows] = name;
      row_op[nrows]   = o;
      row_aluf[nrows] = f;
      row_mode[nrows] = mode;
      row_cin[nrows]  = cin;
      row_a[nrows]    = av;
      row_m[nrows]    = mv;
      if (o == OP_MUL) begin
         p               = mul_model(av, mv);
         row_acc[nrows]  = {p[63], p[63:32]};
         row_q[nrows]    = p[31:0];
         row_aeqm[nrows] = 1'b0;
      end else begin
         r               = alu_model(f, mode, cin, av, mv);
         row_acc[nrows]  = r;
         row_q[nrows]    = '0;
         row_aeqm[nrows] = &r[31:0];
      end
      nrows++;
   endtask

   task automatic launch(input logic o, input logic [3:0] f, input logic mode,
                         input logic cin, input logic [31:0] av, input logic [31:0] mv);
      @(negedge clk);
      op      = o;
      aluf    = f;
      alumode = mode;
      cin0    = cin;
      a       = av;
      m       = mv;
      start   = 1'b1;
      @(negedge clk);
      start   = 1'b0;
   endtask

   task automatic wait_done(input string name, output int cycles);
      int n;
      n = 0;
      while (!done && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      // count includes the cycle that holds the start edge
      cycles = n + 1;
      if (!done) begin
         $display("timeout: o_done never came in test %s", name);
         $display("Test failures found");
         $finish;
      end
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
         errors++;
         test_bad = 1'b1;
      end
   endtask

   task automatic end_test(input string name);
      if (test_bad) begin
         tests_bad++;
         $display("%-14s mismatch", name);
      end else begin
         tests_ok++;
         $display("%-14s ok", name);
      end
      test_bad = 1'b0;
   endtask

   initial begin
      integer      seed;
      int          i;
      int          extra;
      int          cycles;
      logic [31:0] ra;
      logic [31:0] rm;
      logic [63:0] p;
      rst_n    = 1'b0;
      start    = 1'b0;
      op       = OP_ALU;
      aluf     = '0;
      alumode  = 1'b0;
      cin0     = 1'b0;
      a        = '0;
      m        = '0;
      nrows    = 0;
      errors   = 0;
      tests_ok = 0;
      tests_bad = 0;
      test_bad = 1'b0;
      seed     = 32'h834a_2aad;

      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("reset_state", "o_busy", 64'd0, busy);
      check_value("reset_state", "o_done", 64'd0, done);
      check_value("reset_state", "o_acc", 64'd0, acc);
      check_value("reset_state", "o_q", 64'd0, q);
      end_test("reset_state");

      add_row("add_small", OP_ALU, ALUF_ADD, 1'b0, 1'b0, 32'd5, 32'd7);
      add_row("add_cin1", OP_ALU, ALUF_ADD, 1'b0, 1'b1, 32'h1234_5678, 32'h1111_1111);
      add_row("add_pos_ovf", OP_ALU, ALUF_ADD, 1'b0, 1'b0, 32'h7fff_ffff, 32'h0000_0001);
      add_row("add_neg_ovf", OP_ALU, ALUF_ADD, 1'b0, 1'b1, 32'h8000_0000, 32'h8000_0000);
      add_row("add_chain", OP_ALU, ALUF_ADD, 1'b0, 1'b1, 32'hffff_ffff, 32'h0000_0000);
      add_row("logic_and", OP_ALU, 4'b1011, 1'b1, 1'b0, 32'ha5a5_0ff0, 32'h3c3c_f00f);
      add_row("logic_or", OP_ALU, 4'b1110, 1'b1, 1'b0, 32'ha5a5_0ff0, 32'h3c3c_f00f);
      add_row("logic_xor", OP_ALU, 4'b0110, 1'b1, 1'b0, 32'h8a5a_0ff0, 32'h3c3c_f00f);
      add_row("logic_pass_b", OP_ALU, ALUF_PASS_B, 1'b1, 1'b1, 32'h9abc_def0, 32'h1357_9bdf);
      add_row("logic_not_a", OP_ALU, 4'b0000, 1'b1, 1'b0, 32'h0f0f_0f0f, 32'h7654_3210);
      add_row("sub_equal", OP_ALU, ALUF_SUB, 1'b0, 1'b0, 32'hdead_beef, 32'hdead_beef);
      add_row("sub_unequal", OP_ALU, ALUF_SUB, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_01ff);
      add_row("sub_cin1", OP_ALU, ALUF_SUB, 1'b0, 1'b1, 32'h0000_0200, 32'h8000_0010);
      add_row("mul_zero", OP_MUL, 4'd0, 1'b0, 1'b0, 32'h0000_0000, 32'h1234_5678);
      add_row("mul_ones", OP_MUL, 4'd0, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
      add_row("mul_neg", OP_MUL, 4'd0, 1'b0, 1'b0, 32'h0000_1234, 32'h8000_0000);
      add_row("mul_big", OP_MUL, 4'd0, 1'b0, 1'b0, 32'h8000_0001, 32'h7fff_ffff);
      for (i = 0; i < 8; i++) begin
         ra = $random(seed);
         rm = $random(seed);
         add_row($sformatf("mul_rand%0d", i), OP_MUL, 4'd0, 1'b0, 1'b0, ra, rm);
      end

      for (i = 0; i < nrows; i++) begin
         launch(row_op[i], row_aluf[i], row_mode[i], row_cin[i], row_a[i], row_m[i]);
         wait_done(row_name[i], cycles);
         check_value(row_name[i], "latency",
                     (row_op[i] == OP_MUL) ? MUL_CYCLES : ALU_CYCLES, cycles);
         check_value(row_name[i], "o_acc", row_acc[i], acc);
         check_value(row_name[i], "o_q", row_q[i], q);
         check_value(row_name[i], "o_aeqm", row_aeqm[i], aeqm);
         end_test(row_name[i]);
      end

      // second start lands in the middle of the multiply
      launch(OP_MUL, 4'd0, 1'b0, 1'b0, 32'h0000_beef, 32'hffff_fff3);
      repeat (10) @(negedge clk);
      check_value("start_busy", "o_busy", 64'd1, busy);
      launch(OP_ALU, ALUF_ADD, 1'b0, 1'b0, 32'h1111_1111, 32'h2222_2222);
      wait_done("start_busy", cycles);
      p = mul_model(32'h0000_beef, 32'hffff_fff3);
      check_value("start_busy", "o_acc", {p[63], p[63:32]}, acc);
      check_value("start_busy", "o_q", p[31:0], q);
      extra = 0;
      for (i = 0; i < 40; i++) begin
         @(negedge clk);
         if (done) begin
            extra++;
         end
      end
      check_value("start_busy", "extra o_done", 64'd0, extra);
      check_value("start_busy", "o_busy", 64'd0, busy);
      end_test("start_busy");

      $display("%0d tests: %0d ok, %0d with errors, %0d mismatches",
               tests_ok + tests_bad, tests_ok, tests_bad, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* compile.f */
hw/cadr_alu_pkg.sv
hw/alu_slice_181.sv
hw/alu_carry_182.sv
hw/alu_word.sv
hw/alu_shift_regs.sv
hw/alu_step_counter.sv
hw/alu_sequencer.sv
hw/cadr_alu_unit.sv
verif/cadr_alu_props.sv
verif/tb_cadr_alu_unit.sv
